// File: alu_exec.f
+incdir+.
alu_pkg.sv
alu_arith_unit.sv
alu_logic_unit.sv
alu_flag_merge.sv
alu_exec.sv
alu_exec_assertions.sv
tb_alu_exec.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the execute ALU testbench with Verilator, then scan the log
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
SIM_BIN=sim_alu_exec

verilator --binary --timing --assert -f alu_exec.f --top-module tb_alu_exec \
	-Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" +verilator+error+limit+1000 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
	echo "Simulation reported failure"
	exit 1
fi
if ! grep -q "=== PASS ===" "$LOG"; then
	echo "Simulation ended without a result line"
	exit 1
fi
exit 0

// File: tb_alu_exec.sv
// Testbench for the execute ALU driving random and directed ops against a reference model
`timescale 1ns/1ps
`default_nettype none

`include "alu_macros.svh"

module tb_alu_exec
	import alu_pkg::*;
();

	localparam int MAX_CYCLES = 4000;

	// Expected output of one accepted op
	typedef struct packed {
		logic [`ALU_W-1:0] result;
		logic [`ALU_W-1:0] flags;
	} exp_t;

	logic              clk;
	logic              rst_n;
	logic              in_valid;
	alu_req_t          in_req;
	logic              out_valid;
	logic [`ALU_W-1:0] out_result;
	logic [`ALU_W-1:0] out_flags;

	integer            seed = 32'h1e79ec88;
	int                cycles;
	int                result_errs;
	int                flag_errs;
	int                valid_errs;
	int                hold_errs;
	logic              in_valid_d;
	logic [`ALU_W-1:0] model_flags;
	logic [`ALU_W-1:0] prev_result;
	logic [`ALU_W-1:0] prev_flags;
	logic [`ALU_W-1:0] corners [4];
	exp_t              exp_q [$];

	alu_exec u_alu_exec (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_req     (in_req),
		.out_valid  (out_valid),
		.out_result (out_result),
		.out_flags  (out_flags)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	//--------------------------------------------------
	// Reference model
	//--------------------------------------------------
	function automatic exp_t alu_model(input alu_req_t req, input logic [`ALU_W-1:0] fl);
		logic [`ALU_W:0] wide;
		logic [`ALU_W:0] sw;
		logic [7:0]      al;
		logic            status_wr;
		exp_t            e;
		e.flags   = fl;
		e.result  = '0;
		status_wr = 1'b1;
		case (req.op)
			OP_ADD: begin
				wide = {1'b0, req.a} + {1'b0, req.b};
				sw   = {req.a[`ALU_W-1], req.a} + {req.b[`ALU_W-1], req.b};
				e.result = wide[`ALU_W-1:0];
				e.flags[`FLAG_CF] = wide[`ALU_W];
				e.flags[`FLAG_AF] = ({1'b0, req.a[3:0]} + {1'b0, req.b[3:0]}) > 5'd15;
				// Signed sum out of 32-bit range
				e.flags[`FLAG_OF] = sw[`ALU_W] != sw[`ALU_W-1];
			end
			OP_CMP: begin
				// Borrow flags from unsigned compares
				sw = {req.a[`ALU_W-1], req.a} - {req.b[`ALU_W-1], req.b};
				e.result = req.a - req.b;
				e.flags[`FLAG_CF] = req.a < req.b;
				e.flags[`FLAG_AF] = req.a[3:0] < req.b[3:0];
				e.flags[`FLAG_OF] = sw[`ALU_W] != sw[`ALU_W-1];
			end
			OP_OR, OP_AND: begin
				e.result = (req.op == OP_OR) ? (req.a | req.b) : (req.a & req.b);
				e.flags[`FLAG_CF] = 1'b0;
				e.flags[`FLAG_OF] = 1'b0;
			end
			OP_DAA: begin
				// Both tests on the original byte, x86 order
				al = req.a[7:0];
				e.flags[`FLAG_AF] = (al[3:0] > 4'd9) || fl[`FLAG_AF];
				e.flags[`FLAG_CF] = (al > 8'h99) || fl[`FLAG_CF];
				if (e.flags[`FLAG_AF])
					al = al + 8'h06;
				if (e.flags[`FLAG_CF])
					al = al + 8'h60;
				e.result = {{(`ALU_W-8){1'b0}}, al};
			end
			OP_NOT: begin
				e.result  = ~req.a;
				status_wr = 1'b0;
			end
			OP_CLD: begin
				e.flags[`FLAG_DF] = 1'b0;
				status_wr = 1'b0;
			end
			default: begin
				e.flags[`FLAG_DF] = 1'b1;
				status_wr = 1'b0;
			end
		endcase
		// SF from bit 7 for DAA, bit 31 otherwise
		if (status_wr) begin
			e.flags[`FLAG_SF] = (req.op == OP_DAA) ? e.result[7] : e.result[`ALU_W-1];
			e.flags[`FLAG_ZF] = (e.result == '0);
			e.flags[`FLAG_PF] = ~^e.result[7:0];
		end
		return e;
	endfunction

	// Model steps at the accepting edge where inputs are settled
	always @(posedge clk) begin
		exp_t e;
		if (!rst_n) begin
			in_valid_d  <= 1'b0;
			model_flags = `EFLAGS_RESET;
		end else begin
			in_valid_d <= in_valid;
			if (in_valid) begin
				e = alu_model(in_req, model_flags);
				model_flags = e.flags;
				exp_q.push_back(e);
			end
		end
	end

	//--------------------------------------------------
	// Compare
	//--------------------------------------------------
	// Outputs sampled mid-cycle, away from the register edge
	always @(negedge clk) begin
		exp_t e;
		if (rst_n) begin
			assert (out_valid == in_valid_d) else begin
				valid_errs++;
				$display("** Error out_valid: got %h expected %h", out_valid, in_valid_d);
			end
			if (out_valid) begin
				if (exp_q.size() == 0) begin
					valid_errs++;
					$display("Output appeared with no operation pending");
				end else begin
					e = exp_q.pop_front();
					assert (out_result == e.result) else begin
						result_errs++;
						$display("** Error out_result: got %h expected %h", out_result, e.result);
					end
					assert (out_flags == e.flags) else begin
						flag_errs++;
						$display("** Error out_flags: got %h expected %h", out_flags, e.flags);
					end
				end
			end else begin
				assert (out_result == prev_result && out_flags == prev_flags) else begin
					hold_errs++;
					$display("** Error out_result/out_flags held: got %h/%h expected %h/%h",
						out_result, out_flags, prev_result, prev_flags);
				end
			end
			prev_result = out_result;
			prev_flags  = out_flags;
		end
	end

	// Run limit well above the ~2000 cycles of stimulus
	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, %0d results pending", cycles, exp_q.size());
			finish_run(1'b1);
		end
	end

	task automatic finish_run(input logic timed_out);
		int assert_errs;
		assert_errs = u_alu_exec.u_alu_exec_assertions.fail_count;
		$display("Errors: result=%0d flags=%0d valid=%0d hold=%0d assert=%0d",
			result_errs, flag_errs, valid_errs, hold_errs, assert_errs);
		if (!timed_out &&
			(result_errs + flag_errs + valid_errs + hold_errs + assert_errs) == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	endtask

	//--------------------------------------------------
	// Stimulus
	//--------------------------------------------------
	task automatic drive_op(input alu_op_e op, input logic [`ALU_W-1:0] a,
		input logic [`ALU_W-1:0] b);
		@(negedge clk);
		in_valid  = 1'b1;
		in_req.op = op;
		in_req.a  = a;
		in_req.b  = b;
	endtask

	// Idle with junk operands on the bus
	task automatic drive_idle();
		@(negedge clk);
		in_valid = 1'b0;
		in_req.a = $random(seed);
		in_req.b = $random(seed);
	endtask

	// Half of picks hit a corner value
	task automatic pick_operand(output logic [`ALU_W-1:0] v);
		logic [2:0] sel;
		sel = 3'($random(seed));
		v   = sel[2] ? corners[sel[1:0]] : $random(seed);
	endtask

	task automatic pick_op(input logic allow_df, output alu_op_e op);
		do begin
			op = alu_op_e'(3'($random(seed)));
		end while (!allow_df && (op == OP_CLD || op == OP_STD));
	endtask

	task automatic pick_bcd(output logic [7:0] v);
		v[7:4] = 4'($unsigned($random(seed)) % 10);
		v[3:0] = 4'($unsigned($random(seed)) % 10);
	endtask

	// Packed BCD add, then adjust its byte
	task automatic bcd_pair(input logic [7:0] x, input logic [7:0] y);
		drive_op(OP_ADD, {24'd0, x}, {24'd0, y});
		drive_op(OP_DAA, {24'd0, x} + {24'd0, y}, $random(seed));
	endtask

	initial begin
		logic [`ALU_W-1:0] a;
		logic [`ALU_W-1:0] b;
		logic [7:0]        x;
		logic [7:0]        y;
		alu_op_e           op;
		int                gap;
		rst_n       = 1'b0;
		in_valid    = 1'b0;
		in_req      = '0;
		prev_result = '0;
		prev_flags  = `EFLAGS_RESET;
		corners[0]  = 32'h0000_0000;
		corners[1]  = 32'h7fff_ffff;
		corners[2]  = 32'h8000_0000;
		corners[3]  = 32'hffff_ffff;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// Reset state before any op
		assert (out_valid == 1'b0) else begin
			valid_errs++;
			$display("** Error out_valid: got %h expected %h", out_valid, 1'b0);
		end
		assert (out_flags == `EFLAGS_RESET) else begin
			flag_errs++;
			$display("** Error out_flags: got %h expected %h", out_flags, `EFLAGS_RESET);
		end

		// ADD and CMP over all corner pairs, then random
		for (int i = 0; i < 4; i++) begin
			for (int j = 0; j < 4; j++) begin
				drive_op(OP_ADD, corners[i], corners[j]);
				drive_op(OP_CMP, corners[i], corners[j]);
			end
		end
		repeat (300) begin
			pick_operand(a);
			pick_operand(b);
			drive_op(($random(seed) & 1) ? OP_CMP : OP_ADD, a, b);
		end

		// ADD sets AF, CF and OF; OR clears CF and OF while AF survives OR and AND
		drive_op(OP_ADD, 32'h8000_000f, 32'h8000_0001);
		drive_op(OP_OR, 32'h8000_0000, 32'h0000_0001);
		drive_op(OP_AND, 32'hffff_0000, 32'h0000_ffff);
		drive_op(OP_NOT, 32'h1234_5678, 32'h0);
		repeat (200) begin
			pick_operand(a);
			pick_operand(b);
			gap = $unsigned($random(seed)) % 4;
			op  = (gap == 0) ? OP_OR : (gap == 1) ? OP_AND : (gap == 2) ? OP_NOT : OP_ADD;
			drive_op(op, a, b);
		end

		// Decimal carries out of low digit, high digit and both
		bcd_pair(8'h09, 8'h01);
		bcd_pair(8'h90, 8'h10);
		bcd_pair(8'h99, 8'h01);
		bcd_pair(8'h99, 8'h99);
		bcd_pair(8'h58, 8'h48);
		repeat (150) begin
			pick_bcd(x);
			pick_bcd(y);
			bcd_pair(x, y);
		end

		// DF set, then other ops, then cleared
		drive_op(OP_STD, $random(seed), $random(seed));
		repeat (40) begin
			pick_op(1'b0, op);
			drive_op(op, $random(seed), $random(seed));
		end
		drive_op(OP_CLD, $random(seed), $random(seed));
		repeat (40) begin
			pick_op(1'b0, op);
			drive_op(op, $random(seed), $random(seed));
		end

		// Mixed ops with random idle gaps
		repeat (600) begin
			pick_op(1'b1, op);
			pick_operand(a);
			pick_operand(b);
			drive_op(op, a, b);
			gap = $unsigned($random(seed)) % 8;
			if (gap < 3)
				repeat (gap + 1) drive_idle();
		end

		drive_idle();
		while (exp_q.size() != 0)
			@(negedge clk);
		repeat (2) drive_idle();
		finish_run(1'b0);
	end

endmodule

`default_nettype wire

// File: alu_exec_assertions.sv
// Bound checks on execute ALU output timing, output hold and the reserved EFLAGS bit
`timescale 1ns/1ps
`default_nettype none

`include "alu_macros.svh"

module alu_exec_assertions (
	input logic              clk,
	input logic              rst_n,
	input logic              in_valid,
	input logic              out_valid,
	input logic [`ALU_W-1:0] out_result,
	input logic [`ALU_W-1:0] out_flags
);

	// Failed property count
	int fail_count = 0;

	//--------------------------------------------------
	// Valid timing
	//--------------------------------------------------
	// One output per accepted op, exactly one edge later
	a_valid_delay: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid == $past(in_valid))
		else begin
			fail_count++;
			$error("out_valid does not follow in_valid by one cycle");
		end

	//--------------------------------------------------
	// EFLAGS image
	//--------------------------------------------------
	// Reserved bit 1 reads as one once out of reset
	a_reserved_bit: assert property (@(posedge clk) disable iff (!rst_n)
		out_flags[1])
		else begin
			fail_count++;
			$error("reserved bit 1 of out_flags is clear");
		end

	// Idle cycle means nothing was loaded
	a_hold_idle: assert property (@(posedge clk) disable iff (!rst_n)
		!out_valid |-> ($stable(out_flags) && $stable(out_result)))
		else begin
			fail_count++;
			$error("out_flags or out_result changed while out_valid was low");
		end

endmodule

bind alu_exec alu_exec_assertions u_alu_exec_assertions (
	.clk        (clk),
	.rst_n      (rst_n),
	.in_valid   (in_valid),
	.out_valid  (out_valid),
	.out_result (out_result),
	.out_flags  (out_flags)
);

`default_nettype wire

// File: alu_exec.sv
// Execute-stage ALU top joining the arithmetic and logic units to the flag merge stage
`timescale 1ns/1ps
`default_nettype none

`include "alu_macros.svh"

module alu_exec
	import alu_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid,
	input  alu_req_t          in_req,
	output logic              out_valid,
	output logic [`ALU_W-1:0] out_result,
	output logic [`ALU_W-1:0] out_flags
);

	// Unit outputs into merge
	unit_out_t arith_out;
	unit_out_t logic_out;

	// Stored flags fed back for DAA
	logic af_q;
	logic cf_q;

	//--------------------------------------------------
	// Units
	//--------------------------------------------------
	alu_arith_unit u_arith (
		.req       (in_req),
		.arith_out (arith_out)
	);

	alu_logic_unit u_logic (
		.req       (in_req),
		.af_in     (af_q),
		.cf_in     (cf_q),
		.logic_out (logic_out)
	);

	// Single register stage
	alu_flag_merge u_merge (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.op         (in_req.op),
		.arith_out  (arith_out),
		.logic_out  (logic_out),
		.af_q       (af_q),
		.cf_q       (cf_q),
		.out_valid  (out_valid),
		.out_result (out_result),
		.out_flags  (out_flags)
	);

endmodule

`default_nettype wire

// File: alu_flag_merge.sv
// Execute ALU flag merge stage selecting the unit result and registering EFLAGS
`timescale 1ns/1ps
`default_nettype none

`include "alu_macros.svh"

module alu_flag_merge
	import alu_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid,
	input  alu_op_e           op,
	input  unit_out_t         arith_out,
	input  unit_out_t         logic_out,
	output logic              af_q,
	output logic              cf_q,
	output logic              out_valid,
	output logic [`ALU_W-1:0] out_result,
	output logic [`ALU_W-1:0] out_flags
);

	unit_out_t         sel;
	raw_flags_t        wr_mask;
	logic [`ALU_W-1:0] eflags_d;
	logic [`ALU_W-1:0] eflags_q;

	//--------------------------------------------------
	// Unit select
	//--------------------------------------------------
	always_comb begin
		case (op)
			OP_ADD, OP_CMP: begin
				sel = arith_out;
			end
			OP_OR, OP_AND, OP_NOT, OP_DAA: begin
				sel = logic_out;
			end
			default: begin
				// CLD and STD return zero
				sel = '0;
			end
		endcase
	end

	// Per-opcode status flag write enables
	always_comb begin
		wr_mask = '0;
		case (op)
			OP_ADD, OP_CMP: begin
				wr_mask = '1;
			end
			OP_OR, OP_AND: begin
				// AF is kept
				wr_mask    = '1;
				wr_mask.af = 1'b0;
			end
			OP_DAA: begin
				// OF is kept
				wr_mask    = '1;
				wr_mask.of = 1'b0;
			end
			default: begin
				// NOT, CLD and STD leave status flags alone
				wr_mask = '0;
			end
		endcase
	end

	//--------------------------------------------------
	// Next EFLAGS
	//--------------------------------------------------
	// Start from stored value so reserved and unowned bits persist
	always_comb begin
		eflags_d = eflags_q;
		if (wr_mask.of)
			eflags_d[`FLAG_OF] = sel.flags.of;
		if (wr_mask.sf)
			eflags_d[`FLAG_SF] = sel.flags.sf;
		if (wr_mask.zf)
			eflags_d[`FLAG_ZF] = sel.flags.zf;
		if (wr_mask.af)
			eflags_d[`FLAG_AF] = sel.flags.af;
		if (wr_mask.pf)
			eflags_d[`FLAG_PF] = sel.flags.pf;
		if (wr_mask.cf)
			eflags_d[`FLAG_CF] = sel.flags.cf;
		// DF only touched by CLD and STD
		if (op == OP_CLD)
			eflags_d[`FLAG_DF] = 1'b0;
		if (op == OP_STD)
			eflags_d[`FLAG_DF] = 1'b1;
	end

	// Output stage, result and EFLAGS load only on accepted ops
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid  <= 1'b0;
			out_result <= '0;
			eflags_q   <= `EFLAGS_RESET;
		end else begin
			out_valid <= in_valid;
			if (in_valid) begin
				out_result <= sel.result;
				eflags_q   <= eflags_d;
			end
		end
	end

	// Architectural EFLAGS doubles as the output image
	assign out_flags = eflags_q;

	// Stored AF and CF back to DAA
	assign af_q = eflags_q[`FLAG_AF];
	assign cf_q = eflags_q[`FLAG_CF];

endmodule

`default_nettype wire

// File: alu_logic_unit.sv
// Execute ALU logic and decimal unit computing OR, AND, NOT and x86 DAA with flags
`timescale 1ns/1ps
`default_nettype none

`include "alu_macros.svh"

module alu_logic_unit
	import alu_pkg::*;
(
	input  alu_req_t  req,
	input  logic      af_in,
	input  logic      cf_in,
	output unit_out_t logic_out
);

	//--------------------------------------------------
	// BCD digit adjust
	//--------------------------------------------------
	// One digit step, adds 6 on request plus carry from the digit below
	// Bit 4 of the return value is the carry into the next digit
	function automatic logic [4:0] daa_digit(
		input logic [3:0] digit,
		input logic       adjust,
		input logic       carry_in
	);
		logic [4:0] step;
		step = adjust ? 5'd6 : 5'd0;
		daa_digit = {1'b0, digit} + step + {4'd0, carry_in};
	endfunction

	logic [`ALU_W-1:0] res;
	logic [7:0]        daa_byte;
	logic [4:0]        lo_sum;
	logic [4:0]        hi_sum;
	logic              adj_lo;
	logic              adj_hi;
	logic              is_daa;

	// Low digit out of range or stored AF
	assign adj_lo = (req.a[3:0] > 4'd9) | af_in;

	// Whole byte above 99 or stored CF
	// judged on the original byte, not the low-adjusted one
	assign adj_hi = (req.a[7:0] > 8'h99) | cf_in;

	// Low digit first, its carry ripples into the high digit
	assign lo_sum = daa_digit(req.a[3:0], adj_lo, 1'b0);
	assign hi_sum = daa_digit(req.a[7:4], adj_hi, lo_sum[4]);

	// High digit carry is dropped, CF comes from adj_hi
	assign daa_byte = {hi_sum[3:0], lo_sum[3:0]};

	assign is_daa = (req.op == OP_DAA);

	//--------------------------------------------------
	// Result select
	//--------------------------------------------------
	always_comb begin
		case (req.op)
			OP_OR: begin
				res = req.a | req.b;
			end
			OP_AND: begin
				res = req.a & req.b;
			end
			OP_NOT: begin
				res = ~req.a;
			end
			OP_DAA: begin
				// Adjusted byte zero-extended
				res = {{(`ALU_W-8){1'b0}}, daa_byte};
			end
			default: begin
				// Arithmetic and DF ops do not use this unit
				res = '0;
			end
		endcase
	end

	//--------------------------------------------------
	// Flag generation
	//--------------------------------------------------
	assign logic_out.result = res;

	// Logic ops clear OF
	// DAA leaves OF alone through the write mask
	assign logic_out.flags.of = 1'b0;

	// Sign of 8-bit result for DAA, of full word otherwise
	assign logic_out.flags.sf = is_daa ? daa_byte[7] : res[`ALU_W-1];

	// Upper bits are zero for DAA so one compare covers both
	assign logic_out.flags.zf = (res == '0);

	// Only DAA writes AF
	assign logic_out.flags.af = adj_lo;

	// Even parity of low byte
	assign logic_out.flags.pf = ~^res[7:0];

	// Decimal carry for DAA, cleared by OR and AND
	assign logic_out.flags.cf = is_daa ? adj_hi : 1'b0;

endmodule

`default_nettype wire

// File: alu_arith_unit.sv
// Execute ALU arithmetic unit computing ADD and CMP results with x86 status flags
`timescale 1ns/1ps
`default_nettype none

`include "alu_macros.svh"

module alu_arith_unit
	import alu_pkg::*;
(
	input  alu_req_t  req,
	output unit_out_t arith_out
);

	// Sum and difference carry one extra bit for CF
	logic [`ALU_W:0]   sum;
	logic [`ALU_W:0]   diff;
	logic              is_cmp;
	logic [`ALU_W-1:0] res;
	logic              carry;
	logic              b_eff_msb;

	//--------------------------------------------------
	// Adder and subtractor
	//--------------------------------------------------
	// Both run in parallel, op picks one
	assign sum  = {1'b0, req.a} + {1'b0, req.b};
	assign diff = {1'b0, req.a} - {1'b0, req.b};

	// CMP is the only subtracting opcode here
	assign is_cmp = (req.op == OP_CMP);

	// Difference is visible on the result for CMP
	assign res = is_cmp ? diff[`ALU_W-1:0] : sum[`ALU_W-1:0];

	// Bit 32 is carry for ADD and borrow for CMP
	assign carry = is_cmp ? diff[`ALU_W] : sum[`ALU_W];

	// Sign of b as seen by the adder, inverted when subtracting
	assign b_eff_msb = req.b[`ALU_W-1] ^ is_cmp;

	//--------------------------------------------------
	// Flag generation
	//--------------------------------------------------
	assign arith_out.result = res;

	// Signed overflow when operand signs match and result sign flips
	assign arith_out.flags.of = (req.a[`ALU_W-1] == b_eff_msb) &&
		(res[`ALU_W-1] != req.a[`ALU_W-1]);

	// Sign from top bit
	assign arith_out.flags.sf = res[`ALU_W-1];

	// Zero over full width
	assign arith_out.flags.zf = (res == '0);

	// Nibble carry or borrow recovered from bit 4
	// works for sum and difference alike
	assign arith_out.flags.af = req.a[4] ^ req.b[4] ^ res[4];

	// Even parity of low byte
	assign arith_out.flags.pf = ~^res[7:0];

	// Carry out or borrow
	assign arith_out.flags.cf = carry;

endmodule

`default_nettype wire

// File: alu_pkg.sv
// Execute ALU package with the opcode encoding and the structs passed between units
`default_nettype none

`include "alu_macros.svh"

package alu_pkg;

	//--------------------------------------------------
	// Opcodes
	//--------------------------------------------------
	// 3-bit opcode field of the request
	typedef enum logic [2:0] {
		OP_ADD = 3'd0,
		OP_OR  = 3'd1,
		OP_NOT = 3'd2,
		OP_DAA = 3'd3,
		OP_AND = 3'd4,
		OP_CLD = 3'd5,
		OP_CMP = 3'd6,
		OP_STD = 3'd7
	} alu_op_e;

	//--------------------------------------------------
	// Datapath structs
	//--------------------------------------------------
	// Operation request, valid only with in_valid
	typedef struct packed {
		alu_op_e           op;
		logic [`ALU_W-1:0] a;
		logic [`ALU_W-1:0] b;
	} alu_req_t;

	// Six status flags as produced by a unit
	typedef struct packed {
		logic of;
		logic sf;
		logic zf;
		logic af;
		logic pf;
		logic cf;
	} raw_flags_t;

	// Unit result plus raw flags, merged later by opcode
	typedef struct packed {
		logic [`ALU_W-1:0] result;
		raw_flags_t        flags;
	} unit_out_t;

endpackage

`default_nettype wire

// File: alu_macros.svh
// Execute ALU constants for datapath width, EFLAGS bit map and EFLAGS reset image
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// Integer datapath width
`define ALU_W 32

//--------------------------------------------------
// EFLAGS bit positions
//--------------------------------------------------
// Status flags
`define FLAG_CF 0
`define FLAG_PF 2
`define FLAG_AF 4
`define FLAG_ZF 6
`define FLAG_SF 7
// Control flag for string direction
`define FLAG_DF 10
`define FLAG_OF 11

//--------------------------------------------------
// Reset image
//--------------------------------------------------
// Reserved bit 1 always reads as one
`define EFLAGS_RESET 32'h0000_0002

`endif
